// File: source/isa_pkg.sv
package isa_pkg;

  // Architectural register width
  localparam int GPR_SIZE = 64;

  typedef logic [GPR_SIZE-1:0] gpr_t;

  // Operations handled by the execute stage
  typedef enum logic [3:0] {
    FU_OP_PLUS  = 4'd0,
    FU_OP_MINUS = 4'd1,
    FU_OP_ORN   = 4'd2,
    FU_OP_OR    = 4'd3,
    FU_OP_EOR   = 4'd4,
    FU_OP_AND   = 4'd5,
    FU_OP_CSEL  = 4'd6,
    FU_OP_CSINC = 4'd7,
    FU_OP_CSINV = 4'd8,
    FU_OP_CSNEG = 4'd9,
    FU_OP_LDUR  = 4'd10,
    FU_OP_STUR  = 4'd11
  } fu_op_t;

  // ARM condition field encoding
  typedef enum logic [3:0] {
    EQ = 4'h0,
    NE = 4'h1,
    CS = 4'h2,
    CC = 4'h3,
    MI = 4'h4,
    PL = 4'h5,
    VS = 4'h6,
    VC = 4'h7,
    HI = 4'h8,
    LS = 4'h9,
    GE = 4'ha,
    LT = 4'hb,
    GT = 4'hc,
    LE = 4'hd,
    AL = 4'he
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

// File: source/core_pkg.sv
package core_pkg;

  // Reorder buffer indexing
  localparam int ROB_IDX_SIZE = 5;

  typedef logic [ROB_IDX_SIZE-1:0] rob_idx_t;

  // Data memory geometry in doublewords
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_ADDR_SIZE = $clog2(DMEM_WORDS);

  typedef logic [DMEM_ADDR_SIZE-1:0] dmem_addr_t;

  // One operation issued by the reservation station
  typedef struct packed {
    isa_pkg::fu_op_t op;
    isa_pkg::gpr_t   val_a;
    // Offset for loads and stores
    isa_pkg::gpr_t   val_b;
    // Value written by STUR
    isa_pkg::gpr_t   store_data;
    isa_pkg::cond_t  cond;
    logic            set_nzcv;
    isa_pkg::nzcv_t  nzcv;
    rob_idx_t        dst;
  } fu_issue_t;

  // One finished result headed for the ROB
  typedef struct packed {
    rob_idx_t       dst;
    isa_pkg::gpr_t  value;
    logic           set_nzcv;
    isa_pkg::nzcv_t nzcv;
    logic           cond_holds;
  } fu_result_t;

endpackage

// File: source/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::fu_issue_t  issue,
  input  logic                 issue_valid,
  output logic                 issue_ready,
  output core_pkg::fu_result_t res,
  output logic                 res_valid,
  input  logic                 res_ready
);
  import isa_pkg::*;
  import core_pkg::*;

  fu_result_t      res_nxt;
  logic            holds;
  logic [GPR_SIZE:0] sum;
  gpr_t            diff;
  gpr_t            value;
  logic            sign_a;
  logic            sign_b;

  // Condition check against the NZCV carried with the issue
  function automatic logic cond_eval(cond_t cond, nzcv_t f);
    case (cond)
      EQ: return f.z;
      NE: return !f.z;
      CS: return f.c;
      CC: return !f.c;
      MI: return f.n;
      PL: return !f.n;
      VS: return f.v;
      VC: return !f.v;
      HI: return f.c && !f.z;
      LS: return !(f.c && !f.z);
      GE: return f.n == f.v;
      LT: return f.n != f.v;
      GT: return !f.z && (f.n == f.v);
      LE: return !(!f.z && (f.n == f.v));
      default: return 1'b1;
    endcase
  endfunction

  assign sign_a = issue.val_a[GPR_SIZE-1];
  assign sign_b = issue.val_b[GPR_SIZE-1];
  // Extra bit keeps the carry out of the add
  assign sum    = {1'b0, issue.val_a} + {1'b0, issue.val_b};
  assign diff   = issue.val_a - issue.val_b;
  assign holds  = cond_eval(issue.cond, issue.nzcv);

  always_comb begin
    case (issue.op)
      FU_OP_PLUS:  value = sum[GPR_SIZE-1:0];
      FU_OP_MINUS: value = diff;
      FU_OP_ORN:   value = issue.val_a | ~issue.val_b;
      FU_OP_OR:    value = issue.val_a | issue.val_b;
      FU_OP_EOR:   value = issue.val_a ^ issue.val_b;
      FU_OP_AND:   value = issue.val_a & issue.val_b;
      FU_OP_CSEL:  value = holds ? issue.val_a : issue.val_b;
      FU_OP_CSINC: value = holds ? issue.val_a : issue.val_b + 1'b1;
      FU_OP_CSINV: value = holds ? issue.val_a : ~issue.val_b;
      FU_OP_CSNEG: value = holds ? issue.val_a : ~issue.val_b + 1'b1;
      default:     value = '0;
    endcase

    res_nxt.dst        = issue.dst;
    res_nxt.value      = value;
    res_nxt.set_nzcv   = issue.set_nzcv;
    res_nxt.cond_holds = holds;
    res_nxt.nzcv       = issue.nzcv;

    if (issue.set_nzcv) begin
      res_nxt.nzcv.n = value[GPR_SIZE-1];
      res_nxt.nzcv.z = (value == '0);
      case (issue.op)
        FU_OP_PLUS: begin
          res_nxt.nzcv.c = sum[GPR_SIZE];
          res_nxt.nzcv.v = (sign_a == sign_b) && (value[GPR_SIZE-1] != sign_a);
        end
        FU_OP_MINUS: begin
          // Carry set means no borrow
          res_nxt.nzcv.c = (issue.val_a >= issue.val_b);
          res_nxt.nzcv.v = (sign_a != sign_b) && (value[GPR_SIZE-1] != sign_a);
        end
        default: begin
          res_nxt.nzcv.c = 1'b0;
          res_nxt.nzcv.v = 1'b0;
        end
      endcase
    end
  end

  // Free when empty or when the held result leaves this cycle
  assign issue_ready = !res_valid || res_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (issue_valid && issue_ready) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      res <= res_nxt;
    end
  end

  // Memory operations belong to the LSU
  a_no_mem_op: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> (issue.op != FU_OP_LDUR) && (issue.op != FU_OP_STUR));

endmodule

// File: source/lsu_unit.sv
`timescale 1ns/10ps

module lsu_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::fu_issue_t  issue,
  input  logic                 issue_valid,
  output logic                 issue_ready,
  output core_pkg::fu_result_t res,
  output logic                 res_valid,
  input  logic                 res_ready,
  output logic                 wb_cyc,
  output logic                 wb_stb,
  output logic                 wb_we,
  output core_pkg::dmem_addr_t wb_adr,
  output isa_pkg::gpr_t        wb_dat_w,
  input  isa_pkg::gpr_t        wb_dat_r,
  input  logic                 wb_ack
);
  import isa_pkg::*;
  import core_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    BUS,
    DONE
  } lsu_state_t;

  lsu_state_t state;
  fu_issue_t  req;
  gpr_t       addr_sum;

  // Effective address from the latched operands
  assign addr_sum = req.val_a + req.val_b;

  assign issue_ready = (state == IDLE);
  assign res_valid   = (state == DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= IDLE;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (issue_valid) begin
            state <= BUS;
          end
        end
        BUS: begin
          // First BUS cycle drives the address, then wait for ack
          if (!wb_cyc) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= DONE;
          end
        end
        DONE: begin
          if (res_ready) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      req <= issue;
    end
    if (state == BUS && !wb_cyc) begin
      wb_adr   <= addr_sum[DMEM_ADDR_SIZE+2:3];
      wb_we    <= (req.op == FU_OP_STUR);
      wb_dat_w <= req.store_data;
    end
    if (state == BUS && wb_ack) begin
      res.dst        <= req.dst;
      // A store reports the value it wrote
      res.value      <= wb_we ? wb_dat_w : wb_dat_r;
      res.set_nzcv   <= 1'b0;
      res.nzcv       <= req.nzcv;
      res.cond_holds <= 1'b0;
    end
  end

  // Only doubleword aligned accesses are supported
  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (state == BUS && !wb_cyc) |-> (addr_sum[2:0] == 3'b000));

  a_stb_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
                            && $stable(wb_dat_w));

endmodule

// File: source/data_ram.sv
`timescale 1ns/10ps

module data_ram (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  core_pkg::dmem_addr_t wb_adr,
  input  isa_pkg::gpr_t        wb_dat_w,
  output isa_pkg::gpr_t        wb_dat_r,
  output logic                 wb_ack
);
  import isa_pkg::*;
  import core_pkg::*;

  gpr_t mem [DMEM_WORDS];
  logic req;

  initial begin
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // New request only while ack is not already out
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      if (wb_we) begin
        mem[wb_adr] <= wb_dat_w;
      end else begin
        wb_dat_r <= mem[wb_adr];
      end
    end
  end

  // Strobe only inside a bus cycle
  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb |-> wb_cyc);

endmodule

// File: source/result_arbiter.sv
`timescale 1ns/10ps

module result_arbiter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::fu_result_t alu_res,
  input  core_pkg::fu_result_t ls_res,
  input  logic                 alu_valid,
  input  logic                 ls_valid,
  output logic                 alu_ready,
  output logic                 ls_ready,
  output core_pkg::fu_result_t rob_res,
  output logic                 rob_valid,
  input  logic                 rob_ready
);

  // Set when the LSU won the last transfer
  logic last_grant;
  logic grant_ls;

  // LSU wins when alone or when the ALU went last
  always_comb begin
    if (ls_valid && alu_valid) begin
      grant_ls = !last_grant;
    end else begin
      grant_ls = ls_valid;
    end
  end

  assign rob_valid = alu_valid || ls_valid;
  assign rob_res   = grant_ls ? ls_res : alu_res;

  // Loser holds its result, so its ready stays low
  assign alu_ready = rob_ready && !grant_ls;
  assign ls_ready  = rob_ready && grant_ls;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= 1'b1;
    end else if (rob_valid && rob_ready) begin
      last_grant <= grant_ls;
    end
  end

  // Never take both results in one cycle
  a_one_winner: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_valid && ls_valid) |-> !(alu_ready && ls_ready));

  // Units keep a result that was not taken
  a_alu_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (alu_valid && !alu_ready) |=> alu_valid && $stable(alu_res));

  a_ls_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ls_valid && !ls_ready) |=> ls_valid && $stable(ls_res));

endmodule

// File: source/func_units.sv
`timescale 1ns/10ps

module func_units (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::fu_issue_t  alu_issue,
  input  core_pkg::fu_issue_t  ls_issue,
  input  logic                 alu_issue_valid,
  input  logic                 ls_issue_valid,
  output logic                 alu_issue_ready,
  output logic                 ls_issue_ready,
  output core_pkg::fu_result_t rob_res,
  output logic                 rob_valid,
  input  logic                 rob_ready
);
  import isa_pkg::*;
  import core_pkg::*;

  // Unit results toward the arbiter
  fu_result_t alu_res;
  fu_result_t ls_res;
  logic       alu_res_valid;
  logic       alu_res_ready;
  logic       ls_res_valid;
  logic       ls_res_ready;

  // Wishbone between LSU and data memory
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  dmem_addr_t wb_adr;
  gpr_t       wb_dat_w;
  gpr_t       wb_dat_r;
  logic       wb_ack;

  alu_unit u_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (alu_issue),
    .issue_valid (alu_issue_valid),
    .issue_ready (alu_issue_ready),
    .res         (alu_res),
    .res_valid   (alu_res_valid),
    .res_ready   (alu_res_ready)
  );

  lsu_unit u_lsu (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (ls_issue),
    .issue_valid (ls_issue_valid),
    .issue_ready (ls_issue_ready),
    .res         (ls_res),
    .res_valid   (ls_res_valid),
    .res_ready   (ls_res_ready),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack)
  );

  data_ram u_ram (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  result_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_res   (alu_res),
    .ls_res    (ls_res),
    .alu_valid (alu_res_valid),
    .ls_valid  (ls_res_valid),
    .alu_ready (alu_res_ready),
    .ls_ready  (ls_res_ready),
    .rob_res   (rob_res),
    .rob_valid (rob_valid),
    .rob_ready (rob_ready)
  );

endmodule

// File: sim/tb_func_units.sv
`timescale 1ns/10ps

module tb_func_units;
  import isa_pkg::*;
  import core_pkg::*;

  logic       clk;
  logic       rst_n;
  fu_issue_t  alu_issue;
  fu_issue_t  ls_issue;
  logic       alu_issue_valid;
  logic       ls_issue_valid;
  logic       alu_issue_ready;
  logic       ls_issue_ready;
  fu_result_t rob_res;
  logic       rob_valid;
  logic       rob_ready;

  integer     seed;
  int         errors;
  int         checks;
  fu_result_t alu_q[$];
  fu_result_t ls_q[$];
  gpr_t       shadow [DMEM_WORDS];

  func_units u_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .alu_issue       (alu_issue),
    .ls_issue        (ls_issue),
    .alu_issue_valid (alu_issue_valid),
    .ls_issue_valid  (ls_issue_valid),
    .alu_issue_ready (alu_issue_ready),
    .ls_issue_ready  (ls_issue_ready),
    .rob_res         (rob_res),
    .rob_valid       (rob_valid),
    .rob_ready       (rob_ready)
  );

  always #10 clk = ~clk;

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic check_value(string name, gpr_t got, gpr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_nzcv(string name, nzcv_t got, nzcv_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_dst(string name, rob_idx_t got, rob_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  // Condition from the ARM encoding: bits 3..1 pick a test, bit 0 inverts it
  function automatic logic cond_model(cond_t c, nzcv_t f);
    logic base;
    case (c[3:1])
      3'd0: base = f.z;
      3'd1: base = f.c;
      3'd2: base = f.n;
      3'd3: base = f.v;
      3'd4: base = f.c & ~f.z;
      3'd5: base = (f.n == f.v);
      3'd6: base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    return (c[0] && c != AL) ? ~base : base;
  endfunction

  function automatic fu_result_t alu_model(fu_issue_t x);
    fu_result_t        r;
    logic [64:0]        wu;
    logic signed [64:0] ws;
    logic               c;
    logic               v;
    r.dst        = x.dst;
    r.set_nzcv   = x.set_nzcv;
    r.cond_holds = cond_model(x.cond, x.nzcv);
    c = 1'b0;
    v = 1'b0;
    case (x.op)
      FU_OP_PLUS: begin
        wu = {1'b0, x.val_a} + {1'b0, x.val_b};
        ws = $signed({x.val_a[63], x.val_a}) + $signed({x.val_b[63], x.val_b});
        r.value = wu[63:0];
        c = wu[64];
        v = ws[64] != ws[63];
      end
      FU_OP_MINUS: begin
        ws = $signed({x.val_a[63], x.val_a}) - $signed({x.val_b[63], x.val_b});
        r.value = x.val_a - x.val_b;
        c = x.val_a >= x.val_b;
        v = ws[64] != ws[63];
      end
      FU_OP_ORN: r.value = x.val_a | ~x.val_b;
      FU_OP_OR:  r.value = x.val_a | x.val_b;
      FU_OP_EOR: r.value = x.val_a ^ x.val_b;
      FU_OP_AND: r.value = x.val_a & x.val_b;
      FU_OP_CSEL:  r.value = r.cond_holds ? x.val_a : x.val_b;
      FU_OP_CSINC: r.value = r.cond_holds ? x.val_a : x.val_b + 64'd1;
      FU_OP_CSINV: r.value = r.cond_holds ? x.val_a : ~x.val_b;
      default:     r.value = r.cond_holds ? x.val_a : 64'd0 - x.val_b;
    endcase
    r.nzcv = x.nzcv;
    if (x.set_nzcv) begin
      r.nzcv = '{n: r.value[63], z: (r.value == 64'd0), c: c, v: v};
    end
    return r;
  endfunction

  function automatic gpr_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // Compare the result on rob_res with the front of its unit's queue
  task automatic take_result();
    fu_result_t exp;
    if (rob_res.dst[4] ? ls_q.size() == 0 : alu_q.size() == 0) begin
      errors++;
      $display("Unexpected result with dst %h", rob_res.dst);
    end else begin
      exp = rob_res.dst[4] ? ls_q.pop_front() : alu_q.pop_front();
      check_dst("rob_res.dst", rob_res.dst, exp.dst);
      check_value("rob_res.value", rob_res.value, exp.value);
      check_nzcv("rob_res.nzcv", rob_res.nzcv, exp.nzcv);
      check_bit("rob_res.set_nzcv", rob_res.set_nzcv, exp.set_nzcv);
      check_bit("rob_res.cond_holds", rob_res.cond_holds, exp.cond_holds);
    end
  endtask

  task automatic wait_result();
    int t;
    t = 0;
    @(negedge clk);
    while (!(rob_valid && rob_ready)) begin
      t++;
      if (t > 50) begin
        errors++;
        $display("Timeout waiting for a ROB result");
        finish_run();
      end
      @(negedge clk);
    end
    take_result();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_issue(bit to_ls, fu_issue_t x);
    int t;
    t = 0;
    if (to_ls) begin
      ls_issue = x;
      ls_issue_valid = 1'b1;
    end else begin
      alu_issue = x;
      alu_issue_valid = 1'b1;
    end
    @(negedge clk);
    while (!(to_ls ? ls_issue_ready : alu_issue_ready)) begin
      t++;
      if (t > 50) begin
        errors++;
        $display("Timeout waiting for the issue to be accepted");
        finish_run();
      end
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    ls_issue_valid = 1'b0;
    alu_issue_valid = 1'b0;
  endtask

  function automatic fu_issue_t make_alu(fu_op_t op, int dst);
    fu_issue_t x;
    x = '0;
    x.op = op;
    x.val_a = rand64();
    x.val_b = rand64();
    x.cond = AL;
    x.nzcv = nzcv_t'($random(seed));
    x.dst = rob_idx_t'(dst % 16);
    return x;
  endfunction

  // Base plus offset lands on doubleword idx
  function automatic fu_issue_t make_mem(fu_op_t op, int idx, int dst);
    fu_issue_t x;
    x = '0;
    x.op = op;
    x.val_b = rand64() & 64'hffff_fff8;
    x.val_a = (64'(idx) << 3) - x.val_b;
    x.store_data = rand64();
    x.cond = AL;
    x.nzcv = nzcv_t'($random(seed));
    x.dst = rob_idx_t'(16 + dst % 16);
    return x;
  endfunction

  function automatic fu_result_t mem_expect(fu_issue_t x, int idx);
    fu_result_t r;
    r = '0;
    r.dst = x.dst;
    r.nzcv = x.nzcv;
    r.value = (x.op == FU_OP_STUR) ? x.store_data : shadow[idx];
    return r;
  endfunction

  task automatic run_alu(fu_issue_t x);
    alu_q.push_back(alu_model(x));
    drive_issue(1'b0, x);
    wait_result();
  endtask

  task automatic run_mem(fu_op_t op, int idx, int dst);
    fu_issue_t x;
    x = make_mem(op, idx, dst);
    if (op == FU_OP_STUR) begin
      shadow[idx] = x.store_data;
    end
    ls_q.push_back(mem_expect(x, idx));
    drive_issue(1'b1, x);
    wait_result();
  endtask

  task automatic test_arith();
    fu_issue_t x;
    for (int i = 0; i < 40; i++) begin
      x = make_alu(fu_op_t'(($random(seed) & 32'hff) % 6), i);
      x.set_nzcv = i[0];
      alu_q.push_back(alu_model(x));
      drive_issue(1'b0, x);
      // Result must be visible right after the accepting edge
      check_bit("rob_valid", rob_valid, 1'b1);
      wait_result();
    end
  endtask

  task automatic test_csel();
    nzcv_t     flags [4] = '{4'b0010, 4'b0110, 4'b1001, 4'b1110};
    fu_issue_t x;
    for (int op = 6; op <= 9; op++) begin
      for (int c = 0; c < 15; c++) begin
        for (int f = 0; f < 4; f++) begin
          x = make_alu(fu_op_t'(op), c);
          x.cond = cond_t'(c);
          x.nzcv = flags[f];
          run_alu(x);
        end
      end
    end
  endtask

  task automatic test_mem();
    int idx [8];
    for (int i = 0; i < 8; i++) begin
      idx[i] = ($random(seed) & 32'hff);
      run_mem(FU_OP_STUR, idx[i], i);
    end
    for (int i = 0; i < 8; i++) begin
      run_mem(FU_OP_LDUR, idx[i], i + 8);
    end
  endtask

  task automatic test_contention();
    fu_issue_t a;
    fu_issue_t m;
    for (int k = 0; k < 4; k++) begin
      // A lone transfer sets which unit went last
      if (k % 2 == 0) begin
        run_mem(FU_OP_LDUR, k, k);
      end else begin
        run_alu(make_alu(FU_OP_PLUS, k));
      end
      a = make_alu(FU_OP_EOR, k + 4);
      m = make_mem(FU_OP_LDUR, k + 10, k + 4);
      alu_q.push_back(alu_model(a));
      ls_q.push_back(mem_expect(m, k + 10));
      rob_ready = 1'b0;
      alu_issue = a;
      ls_issue = m;
      alu_issue_valid = 1'b1;
      ls_issue_valid = 1'b1;
      @(posedge clk);
      #2;
      alu_issue_valid = 1'b0;
      ls_issue_valid = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      check_bit("rob_valid", rob_valid, 1'b1);
      // Winner is the unit that did not go last
      check_bit("rob_res.dst[4]", rob_res.dst[4], (k % 2 == 1));
      rob_ready = 1'b1;
      wait_result();
      wait_result();
    end
  endtask

  task automatic test_backpressure();
    fu_issue_t x;
    int        got;
    int        t;
    logic      accepted;
    rob_ready = 1'b0;
    x = make_alu(FU_OP_OR, 1);
    alu_q.push_back(alu_model(x));
    drive_issue(1'b0, x);
    run_mem_issue_only();
    alu_issue = make_alu(FU_OP_AND, 2);
    alu_q.push_back(alu_model(alu_issue));
    alu_issue_valid = 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_bit("alu_issue_ready", alu_issue_ready, 1'b0);
      if (i > 4) begin
        check_bit("ls_issue_ready", ls_issue_ready, 1'b0);
      end
      check_bit("rob_valid", rob_valid, 1'b1);
    end
    @(posedge clk);
    #2;
    rob_ready = 1'b1;
    got = 0;
    t = 0;
    while (got < 3) begin
      t++;
      if (t > 50) begin
        errors++;
        $display("Timeout waiting for results after release");
        finish_run();
      end
      @(negedge clk);
      if (rob_valid) begin
        take_result();
        got++;
      end
      accepted = alu_issue_valid && alu_issue_ready;
      @(posedge clk);
      #2;
      if (accepted) begin
        alu_issue_valid = 1'b0;
      end
    end
  endtask

  task automatic run_mem_issue_only();
    fu_issue_t m;
    m = make_mem(FU_OP_LDUR, 7, 3);
    ls_q.push_back(mem_expect(m, 7));
    drive_issue(1'b1, m);
  endtask

  initial begin
    seed = 32'h5a52;
    errors = 0;
    checks = 0;
    clk = 1'b0;
    rst_n = 1'b0;
    alu_issue = '0;
    ls_issue = '0;
    alu_issue_valid = 1'b0;
    ls_issue_valid = 1'b0;
    rob_ready = 1'b1;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    test_arith();
    test_csel();
    test_mem();
    test_contention();
    test_backpressure();
    if (alu_q.size() != 0 || ls_q.size() != 0) begin
      errors++;
      $display("Some expected results never arrived");
    end
    finish_run();
  end

endmodule

// File: build.f
source/isa_pkg.sv
source/core_pkg.sv
source/alu_unit.sv
source/lsu_unit.sv
source/data_ram.sv
source/result_arbiter.sv
source/func_units.sv
sim/tb_func_units.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_func_units -f build.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
